// ==== verilog/lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// memory window of the slave
`define LSU_MEM_BASE  32'h8000_0000
`define LSU_MEM_WORDS 256

// slack cycles on top of the per-operation budget
`define LSU_TB_MARGIN 200

`endif

// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

    // access width of a load or store
    typedef enum logic [1:0] {
        LSU_BYTE = 2'd0,
        LSU_HALF = 2'd1,
        LSU_WORD = 2'd2
    } lsu_size_e;

    // AXI xRESP encoding
    typedef enum logic [1:0] {
        AXI_OKAY   = 2'b00,
        AXI_EXOKAY = 2'b01,
        AXI_SLVERR = 2'b10,
        AXI_DECERR = 2'b11
    } axi_resp_e;

endpackage

// ==== verilog/lsu_read_port.sv ====
`timescale 1ns/1ps

module lsu_read_port import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        rd_start,
    input  logic [31:0] rd_addr,
    output logic        rd_done,
    output logic [31:0] rd_data,
    output logic        rd_err,
    output logic        ar_valid,
    input  logic        ar_ready,
    output logic [31:0] ar_addr,
    input  logic        r_valid,
    output logic        r_ready,
    input  logic [31:0] r_data,
    input  axi_resp_e   r_resp
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ar_valid <= 1'b0;
            r_ready  <= 1'b0;
        end else begin
            if (ar_valid && ar_ready)
                ar_valid <= 1'b0;
            if (r_valid && r_ready)
                r_ready <= 1'b0;
            if (rd_start) begin
                ar_valid <= 1'b1;
                r_ready  <= 1'b1;   // ready for data from the issue on
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start)
            ar_addr <= {rd_addr[31:2], 2'b00};  // always fetch the whole word
    end

    // completion is the R handshake itself
    assign rd_done = r_valid && r_ready;
    assign rd_data = r_data;
    assign rd_err  = (r_resp != AXI_OKAY);

    ar_addr_stable: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else $error("ar_addr changed while ar_valid waited");

endmodule

// ==== verilog/lsu_write_port.sv ====
`timescale 1ns/1ps

module lsu_write_port import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_start,
    input  logic [31:0] wr_addr,
    input  logic [31:0] wr_data,
    input  lsu_size_e   wr_size,
    output logic        wr_done,
    output logic        wr_err,
    output logic        aw_valid,
    input  logic        aw_ready,
    output logic [31:0] aw_addr,
    output logic        w_valid,
    input  logic        w_ready,
    output logic [31:0] w_data,
    output logic [3:0]  w_strb,
    input  logic        b_valid,
    output logic        b_ready,
    input  axi_resp_e   b_resp
);

    logic [1:0] byte_off;
    logic [3:0] strb_base;

    assign byte_off = wr_addr[1:0];

    always_comb begin
        case (wr_size)
            LSU_BYTE: strb_base = 4'b0001;
            LSU_HALF: strb_base = 4'b0011;
            default:  strb_base = 4'b1111;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            b_ready  <= 1'b0;
        end else begin
            // each channel drops on its own handshake
            if (aw_valid && aw_ready)
                aw_valid <= 1'b0;
            if (w_valid && w_ready)
                w_valid <= 1'b0;
            if (b_valid && b_ready)
                b_ready <= 1'b0;
            if (wr_start) begin
                aw_valid <= 1'b1;
                w_valid  <= 1'b1;
                b_ready  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_start) begin
            aw_addr <= {wr_addr[31:2], 2'b00};
            w_data  <= wr_data << {byte_off, 3'b000};   // move data into its lane
            w_strb  <= strb_base << byte_off;
        end
    end

    assign wr_done = b_valid && b_ready;
    assign wr_err  = (b_resp != AXI_OKAY);

    w_beat_stable: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_strb))
        else $error("write beat changed while w_valid waited");

endmodule

// ==== verilog/lsu_ctrl.sv ====
`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic        op_load,
    input  logic        op_store,
    input  lsu_size_e   size,
    input  logic        sign_ext,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] result,
    output logic        fault,
    output logic        rd_start,
    output logic [31:0] rd_addr,
    input  logic        rd_done,
    input  logic [31:0] rd_data,
    input  logic        rd_err,
    output logic        wr_start,
    output logic [31:0] wr_addr,
    output logic [31:0] wr_data,
    output lsu_size_e   wr_size,
    input  logic        wr_done,
    input  logic        wr_err
);

    typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_HOLD} state_e;

    state_e      state;
    logic        accept;
    logic        misaligned;
    logic [1:0]  off_q;
    lsu_size_e   size_q;
    logic        sext_q;
    logic [31:0] lane;
    logic [31:0] load_val;

    assign in_ready  = (state == ST_IDLE);
    assign out_valid = (state == ST_HOLD);
    assign accept    = in_valid && in_ready;

    always_comb begin
        case (size)
            LSU_HALF: misaligned = addr[0];
            LSU_WORD: misaligned = (addr[1:0] != 2'b00);
            default:  misaligned = 1'b0;
        endcase
    end

    // a load wins if both flags are set
    assign rd_start = accept && op_load && !misaligned;
    assign wr_start = accept && op_store && !op_load && !misaligned;
    assign rd_addr  = addr;
    assign wr_addr  = addr;
    assign wr_data  = wdata;
    assign wr_size  = size;

    assign lane = rd_data >> {off_q, 3'b000};

    always_comb begin
        case (size_q)
            LSU_BYTE: load_val = {{24{sext_q & lane[7]}}, lane[7:0]};
            LSU_HALF: load_val = {{16{sext_q & lane[15]}}, lane[15:0]};
            default:  load_val = rd_data;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (accept) state <= (rd_start || wr_start) ? ST_BUSY : ST_HOLD;
                ST_BUSY: if (rd_done || wr_done) state <= ST_HOLD;
                ST_HOLD: if (out_ready) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            off_q  <= addr[1:0];
            size_q <= size;
            sext_q <= sign_ext;
            if (misaligned && (op_load || op_store)) begin
                result <= 32'h0;
                fault  <= 1'b1;
            end else begin
                result <= addr;     // pass-through value until a port completes
                fault  <= 1'b0;
            end
        end else if (rd_done) begin
            result <= rd_err ? 32'h0 : load_val;
            fault  <= rd_err;
        end else if (wr_done) begin
            result <= 32'h0;
            fault  <= wr_err;
        end
    end

    port_done_busy: assert property (@(posedge clk) disable iff (rst)
        (rd_done || wr_done) |-> state == ST_BUSY && !(rd_done && wr_done))
        else $error("port completion outside a single outstanding operation");

endmodule

// ==== verilog/axi_sram.sv ====
`timescale 1ns/1ps
`include "lsu_settings.svh"

module axi_sram import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        ar_valid,
    output logic        ar_ready,
    input  logic [31:0] ar_addr,
    output logic        r_valid,
    input  logic        r_ready,
    output logic [31:0] r_data,
    output axi_resp_e   r_resp,
    input  logic        aw_valid,
    output logic        aw_ready,
    input  logic [31:0] aw_addr,
    input  logic        w_valid,
    output logic        w_ready,
    input  logic [31:0] w_data,
    input  logic [3:0]  w_strb,
    output logic        b_valid,
    input  logic        b_ready,
    output axi_resp_e   b_resp
);

    localparam int unsigned WORDS = `LSU_MEM_WORDS;
    localparam int unsigned IDX_W = $clog2(WORDS);
    localparam logic [31:0] SPAN  = 32'(WORDS * 4);

    logic [31:0] mem [WORDS];
    logic [31:0] rd_off;
    logic [31:0] wr_off;
    logic        rd_hit;
    logic        wr_hit;
    logic        rd_fire;
    logic        wr_fire;

    // below-base addresses wrap to large offsets and miss too
    assign rd_off = ar_addr - `LSU_MEM_BASE;
    assign wr_off = aw_addr - `LSU_MEM_BASE;
    assign rd_hit = (rd_off < SPAN);
    assign wr_hit = (wr_off < SPAN);

    assign ar_ready = !r_valid;     // one read outstanding
    assign aw_ready = w_valid && !b_valid;
    assign w_ready  = aw_valid && !b_valid;
    assign rd_fire  = ar_valid && ar_ready;
    assign wr_fire  = aw_valid && w_valid && !b_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            r_valid <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            if (rd_fire)
                r_valid <= 1'b1;
            else if (r_valid && r_ready)
                r_valid <= 1'b0;
            if (wr_fire)
                b_valid <= 1'b1;
            else if (b_valid && b_ready)
                b_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            r_data <= rd_hit ? mem[rd_off[IDX_W+1:2]] : 32'h0;
            r_resp <= rd_hit ? AXI_OKAY : AXI_SLVERR;
        end
        if (wr_fire) begin
            b_resp <= wr_hit ? AXI_OKAY : AXI_SLVERR;
            if (wr_hit) begin
                for (int i = 0; i < 4; i++) begin
                    if (w_strb[i])
                        mem[wr_off[IDX_W+1:2]][8*i +: 8] <= w_data[8*i +: 8];
                end
            end
        end
    end

    aw_request_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
        else $error("write address withdrawn or changed before acceptance");

endmodule

// ==== verilog/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic        op_load,
    input  logic        op_store,
    input  lsu_size_e   size,
    input  logic        sign_ext,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] result,
    output logic        fault
);

    logic        rd_start, rd_done, rd_err;
    logic [31:0] rd_addr, rd_data;
    logic        wr_start, wr_done, wr_err;
    logic [31:0] wr_addr, wr_data;
    lsu_size_e   wr_size;

    logic        ar_valid, ar_ready, r_valid, r_ready;
    logic [31:0] ar_addr, r_data;
    axi_resp_e   r_resp;
    logic        aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic [31:0] aw_addr, w_data;
    logic [3:0]  w_strb;
    axi_resp_e   b_resp;

    lsu_ctrl u_ctrl (.*);

    lsu_read_port u_rd (.*);

    lsu_write_port u_wr (.*);

    axi_sram u_mem (.*);

endmodule

// ==== verification/lsu_tb.sv ====
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam logic [31:0] BASE  = `LSU_MEM_BASE;
    localparam logic [31:0] SPAN  = 32'(`LSU_MEM_WORDS * 4);
    localparam int          IDX_W = $clog2(`LSU_MEM_WORDS);
    localparam int          N_OPS = 44;     // operations issued over all tests
    localparam int          LIMIT = N_OPS * 10 + `LSU_TB_MARGIN;

    logic        clk = 1'b0;
    logic        rst, in_valid, in_ready, op_load, op_store, sign_ext;
    logic        out_valid, out_ready, fault;
    logic [31:0] addr, wdata, result;
    lsu_size_e   size;

    logic [31:0] model [`LSU_MEM_WORDS];   // reference copy of the memory window
    logic [31:0] lcg_state = 32'h9c2a_aff2;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    lsu_top uut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("timeout: no result after %0d cycles", LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [IDX_W-1:0] word_index(input logic [31:0] a);
        logic [31:0] off;
        off = a - BASE;
        return off[IDX_W+1:2];
    endfunction

    function automatic void model_store(input logic [31:0] a, input logic [31:0] d,
                                        input lsu_size_e sz);
        int n;
        n = (sz == LSU_BYTE) ? 1 : ((sz == LSU_HALF) ? 2 : 4);
        for (int i = 0; i < n; i++)
            model[word_index(a)][8 * (int'(a[1:0]) + i) +: 8] = d[8 * i +: 8];
    endfunction

    function automatic logic [31:0] expect_load(input logic [31:0] a, input lsu_size_e sz,
                                                input logic sx);
        logic [31:0] word;
        int          b;
        word = model[word_index(a)];
        b = 8 * int'(a[1:0]);
        case (sz)
            LSU_BYTE: return {{24{sx & word[b + 7]}}, word[b +: 8]};
            LSU_HALF: return {{16{sx & word[b + 15]}}, word[b +: 16]};
            default:  return word;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error @%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // drives one operation and returns once out_valid is seen
    task automatic do_op(input logic ld, input logic st, input logic [31:0] a,
                         input logic [31:0] d, input lsu_size_e sz, input logic sx,
                         output logic [31:0] res, output logic flt);
        @(negedge clk);
        in_valid = 1'b1;
        op_load  = ld;
        op_store = st;
        addr     = a;
        wdata    = d;
        size     = sz;
        sign_ext = sx;
        while (!in_ready)
            @(negedge clk);
        @(negedge clk);     // accepted on the edge in between
        in_valid = 1'b0;
        while (!out_valid)
            @(negedge clk);
        res = result;
        flt = fault;
    endtask

    task automatic store_check(input logic [31:0] a, input logic [31:0] d,
                               input lsu_size_e sz);
        logic [31:0] res;
        logic        flt;
        do_op(1'b0, 1'b1, a, d, sz, 1'b0, res, flt);
        check_value("store result", res, 32'h0);
        check_bit("store fault", flt, 1'b0);
        model_store(a, d, sz);
    endtask

    task automatic load_check(input logic [31:0] a, input lsu_size_e sz, input logic sx);
        logic [31:0] res;
        logic        flt;
        do_op(1'b1, 1'b0, a, 32'h0, sz, sx, res, flt);
        check_value("load result", res, expect_load(a, sz, sx));
        check_bit("load fault", flt, 1'b0);
    endtask

    task automatic fault_check(input logic ld, input logic st, input logic [31:0] a,
                               input lsu_size_e sz);
        logic [31:0] res;
        logic        flt;
        do_op(ld, st, a, next_rand(), sz, 1'b0, res, flt);
        check_bit("fault flag", flt, 1'b1);
        if (ld)
            check_value("faulted load result", res, 32'h0);
    endtask

    task automatic test_reset_state();
        check_bit("in_ready after reset", in_ready, 1'b1);
        check_bit("out_valid after reset", out_valid, 1'b0);
    endtask

    task automatic test_word_round_trip();
        for (int k = 0; k < 8; k++)
            store_check(BASE + 32'(k * 36), next_rand(), LSU_WORD);
        for (int k = 0; k < 8; k++)
            load_check(BASE + 32'(k * 36), LSU_WORD, 1'b0);
    endtask

    task automatic test_lanes();
        store_check(BASE + 32'h200, next_rand(), LSU_WORD);
        store_check(BASE + 32'h201, next_rand() | 32'h80, LSU_BYTE);     // top bit set
        store_check(BASE + 32'h202, next_rand() | 32'h8000, LSU_HALF);
        for (int off = 0; off < 4; off++) begin
            for (int sx = 0; sx < 2; sx++)
                load_check(BASE + 32'h200 + 32'(off), LSU_BYTE, sx[0]);
        end
        for (int off = 0; off < 4; off += 2) begin
            for (int sx = 0; sx < 2; sx++)
                load_check(BASE + 32'h200 + 32'(off), LSU_HALF, sx[0]);
        end
        load_check(BASE + 32'h200, LSU_WORD, 1'b0);
    endtask

    task automatic test_faults();
        fault_check(1'b0, 1'b1, BASE + SPAN + 32'h24, LSU_WORD);   // would alias word 9
        load_check(BASE + 32'h24, LSU_WORD, 1'b0);
        fault_check(1'b1, 1'b0, BASE - 32'h4, LSU_WORD);
        fault_check(1'b1, 1'b0, BASE + SPAN, LSU_WORD);
        fault_check(1'b1, 1'b0, BASE + 32'h201, LSU_HALF);
        fault_check(1'b0, 1'b1, BASE + 32'h203, LSU_HALF);
        fault_check(1'b0, 1'b1, BASE + 32'h202, LSU_WORD);
        fault_check(1'b1, 1'b0, BASE + 32'h201, LSU_WORD);
        load_check(BASE + 32'h200, LSU_WORD, 1'b0);
    endtask

    task automatic test_pass_through();
        logic [31:0] a;
        logic [31:0] res;
        logic        flt;
        for (int k = 0; k < 2; k++) begin
            a = next_rand();
            do_op(1'b0, 1'b0, a, 32'h0, LSU_WORD, 1'b0, res, flt);
            check_value("pass-through result", res, a);
            check_bit("pass-through fault", flt, 1'b0);
        end
    endtask

    task automatic test_back_pressure();
        logic [31:0] res;
        logic        flt;
        @(negedge clk);     // let the previous result leave first
        out_ready = 1'b0;
        do_op(1'b1, 1'b0, BASE + 32'h48, 32'h0, LSU_WORD, 1'b0, res, flt);
        check_value("held load result", res, expect_load(BASE + 32'h48, LSU_WORD, 1'b0));
        check_bit("held load fault", flt, 1'b0);
        repeat (5) begin
            @(negedge clk);
            check_bit("out_valid while stalled", out_valid, 1'b1);
            check_value("result while stalled", result, res);
            check_bit("fault while stalled", fault, flt);
            check_bit("in_ready while stalled", in_ready, 1'b0);
        end
        out_ready = 1'b1;
        @(negedge clk);
        check_bit("out_valid after release", out_valid, 1'b0);
        check_bit("in_ready after release", in_ready, 1'b1);
    endtask

    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        op_load   = 1'b0;
        op_store  = 1'b0;
        addr      = 32'h0;
        wdata     = 32'h0;
        size      = LSU_WORD;
        sign_ext  = 1'b0;
        out_ready = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        test_reset_state();
        test_word_round_trip();
        test_lanes();
        test_faults();
        test_pass_through();
        test_back_pressure();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_read_port.sv
verilog/lsu_write_port.sv
verilog/lsu_ctrl.sv
verilog/axi_sram.sv
verilog/lsu_top.sv
verification/lsu_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build lsu_tb with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f build.f --top-module lsu_tb -Mdir obj_dir
	./obj_dir/Vlsu_tb | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
